// ==== fds_pkg.sv ====
// FDS RAM adapter shared bus types, register map, timing and memory layout
`default_nettype none

package fds_pkg;

	// One CPU access, read and write count only with ce
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  din;
		logic        read;
		logic        write;
		logic        ce;
	} cpu_bus_t;

	// Fields of the $4025 drive control register
	typedef struct packed {
		logic motor_on;
		logic disk_reset;
		logic write_en;      // High selects read mode
		logic vertical;      // Vertical mirroring
		logic byte_transfer;
		logic disk_irq_en;
	} drive_ctrl_t;

	// CPU-visible registers
	localparam logic [15:0] REG_TIMER_LO     = 16'h4020;
	localparam logic [15:0] REG_TIMER_HI     = 16'h4021;
	localparam logic [15:0] REG_TIMER_CTRL   = 16'h4022;
	localparam logic [15:0] REG_IO_EN        = 16'h4023;
	localparam logic [15:0] REG_DATA_WR      = 16'h4024;
	localparam logic [15:0] REG_DRIVE_CTRL   = 16'h4025;
	localparam logic [15:0] REG_SIDE         = 16'h4027;
	localparam logic [15:0] REG_IRQ_STATUS   = 16'h4030;
	localparam logic [15:0] REG_DATA_RD      = 16'h4031;
	localparam logic [15:0] REG_DRIVE_STATUS = 16'h4032;
	localparam logic [15:0] REG_EXT          = 16'h4033;

	// Shortened drive timing, in ce ticks
	localparam logic [19:0] PRE_GAP_DELAY = 20'd65535;
	localparam logic [19:0] BYTE_DELAY    = 20'd99;

	// Disk image layout
	localparam logic [17:0] SIDE_SIZE    = 18'd65500;
	localparam logic [17:0] DISK_END_POS = 18'd65499;
	localparam logic [17:0] SIDE_HEADER  = 18'd16;      // Image file header

	localparam logic [21:0] DISK_BASE = 22'h3C0000;
	localparam logic [21:0] WRAM_BASE = 22'h208000;
	localparam logic [21:0] CHR_BASE  = 22'h200000;

	localparam logic [7:0] START_MARK = 8'h80;         // Gap end mark before block data

	// Last byte offset per block type, CRC bytes are absent from images
	localparam logic [15:0] BLK1_LAST = 16'h0037;
	localparam logic [15:0] BLK2_LAST = 16'h0001;
	localparam logic [15:0] BLK3_LAST = 16'h000F;

	// File size field inside a file header block
	localparam logic [15:0] FILE_SIZE_LO_POS = 16'h000D;
	localparam logic [15:0] FILE_SIZE_HI_POS = 16'h000E;

endpackage

`default_nettype wire

// ==== fds_timer_irq.sv ====
// Reloadable 16-bit CPU cycle timer raising the FDS timer IRQ
`default_nettype none

module fds_timer_irq (
	input  wire               clk,
	input  wire               reset,
	input  wire fds_pkg::cpu_bus_t cpu,
	input  wire               io_en,
	input  wire               status_read_ack,
	output logic              timer_irq
);
	import fds_pkg::*;

	logic [15:0] latch;
	logic [15:0] count;
	logic        timer_en;
	logic        timer_repeat;
	logic        ctrl_wr;
	logic        load;

	assign ctrl_wr = cpu.ce && cpu.write && cpu.addr == REG_TIMER_CTRL;
	assign load    = ctrl_wr && cpu.din[1] && io_en;   // Start only with disk I/O enabled

	always_ff @(posedge clk) begin
		if (cpu.ce && cpu.write && cpu.addr == REG_TIMER_LO)
			latch[7:0] <= cpu.din;
		if (cpu.ce && cpu.write && cpu.addr == REG_TIMER_HI)
			latch[15:8] <= cpu.din;
		if (load)
			count <= latch;
		else if (cpu.ce && timer_en)
			count <= (count == 16'd0) ? latch : count - 16'd1;   // Reload on expiry
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			timer_en     <= 1'b0;
			timer_repeat <= 1'b0;
			timer_irq    <= 1'b0;
		end else if (cpu.ce) begin
			if (timer_en && count == 16'd0) begin
				timer_irq <= 1'b1;
				if (!timer_repeat)
					timer_en <= 1'b0;   // One-shot stops here
			end
			if (ctrl_wr) begin
				timer_repeat <= cpu.din[0];
				timer_en     <= load;
				if (!load)
					timer_irq <= 1'b0;
			end
			if (!io_en) begin
				timer_en  <= 1'b0;
				timer_irq <= 1'b0;
			end
			if (status_read_ack)
				timer_irq <= 1'b0;   // Acknowledged through $4030
		end
	end

endmodule

`default_nettype wire

// ==== fds_disk_drive.sv ====
// Disk drive emulation with motor, pre-gap, byte slots, ready flag and disk position
`default_nettype none

module fds_disk_drive (
	input  wire                  clk,
	input  wire                  reset,
	input  wire fds_pkg::cpu_bus_t cpu,
	input  wire                  eject_btn,
	input  wire                  block_end,
	output fds_pkg::drive_ctrl_t ctrl,
	output logic                 io_en,
	output logic [1:0]           side,
	output logic [15:0]          disk_pos,
	output logic                 byte_flag,
	output logic                 disk_end,
	output logic                 disk_write,
	output logic                 disk_read_strobe,
	output logic                 new_transfer,
	output logic                 byte_done,
	output logic                 status_read_ack
);
	import fds_pkg::*;

	logic [19:0] transfer_cnt;
	logic        after_pre_gap;
	logic        new_byte;      // Slot not yet consumed
	logic        got_start;
	logic        got_start_d;
	logic        read_d;
	logic        write_d;
	logic        ctrl_wr;
	logic        data_wr;

	assign ctrl_wr = cpu.write && cpu.addr == REG_DRIVE_CTRL;
	assign data_wr = cpu.write && cpu.addr == REG_DATA_WR;

	// Transfer bit rising starts a new block
	assign new_transfer = cpu.ce && ctrl_wr && !ctrl.byte_transfer && cpu.din[6];

	assign disk_read_strobe = cpu.read && cpu.addr == REG_DATA_RD;
	assign disk_write = data_wr && !ctrl.write_en && ctrl.byte_transfer && got_start_d
		&& ctrl.motor_on && !ctrl.disk_reset && !block_end;

	assign byte_done = cpu.ce && new_byte && ((read_d && ctrl.write_en) || write_d);
	assign disk_end  = {2'b00, disk_pos} == DISK_END_POS;

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl            <= '{write_en: 1'b1, default: 1'b0};
			io_en           <= 1'b0;
			side            <= 2'd0;
			disk_pos        <= 16'd0;
			byte_flag       <= 1'b0;
			new_byte        <= 1'b0;
			got_start       <= 1'b0;
			got_start_d     <= 1'b0;
			after_pre_gap   <= 1'b0;
			transfer_cnt    <= 20'd0;
			read_d          <= 1'b0;
			write_d         <= 1'b0;
			status_read_ack <= 1'b0;
		end else if (cpu.ce) begin
			got_start_d     <= got_start;
			read_d          <= disk_read_strobe;
			write_d         <= disk_write;
			status_read_ack <= cpu.read && cpu.addr == REG_IRQ_STATUS;

			if (cpu.write) begin
				case (cpu.addr)
					REG_IO_EN: io_en <= cpu.din[0];
					REG_DATA_WR: begin
						byte_flag <= 1'b0;
						if (!ctrl.write_en && ctrl.byte_transfer && cpu.din == START_MARK)
							got_start <= 1'b1;
					end
					REG_DRIVE_CTRL: begin
						ctrl.motor_on      <= cpu.din[0];
						ctrl.disk_reset    <= cpu.din[1];
						ctrl.write_en      <= cpu.din[2];
						ctrl.vertical      <= !cpu.din[3];
						ctrl.byte_transfer <= cpu.din[6];
						ctrl.disk_irq_en   <= cpu.din[7];
					end
					REG_SIDE: side <= cpu.din[1:0];
					default: ;
				endcase
			end

			if (new_transfer) begin
				byte_flag   <= !cpu.din[2];   // Write mode wants data at once
				new_byte    <= 1'b0;
				got_start   <= 1'b0;
				got_start_d <= 1'b0;
			end

			if (status_read_ack || read_d)
				byte_flag <= 1'b0;

			if (byte_done) begin
				new_byte <= 1'b0;
				if (!disk_end && !block_end)
					disk_pos <= disk_pos + 16'd1;
			end

			// Pre-gap first, then one slot per byte time
			transfer_cnt <= transfer_cnt + 20'd1;
			if (ctrl.disk_reset) begin
				transfer_cnt  <= 20'd0;
				disk_pos      <= 16'd0;
				after_pre_gap <= 1'b0;
			end else if (!ctrl.motor_on) begin
				transfer_cnt <= 20'd0;
			end else if (!after_pre_gap) begin
				if (transfer_cnt == PRE_GAP_DELAY) begin
					after_pre_gap <= 1'b1;
					transfer_cnt  <= 20'd0;
				end
			end else if (transfer_cnt == BYTE_DELAY) begin
				transfer_cnt <= 20'd0;
				if (ctrl.byte_transfer && !eject_btn) begin   // No data with disk out
					byte_flag <= 1'b1;
					new_byte  <= 1'b1;
				end
			end
			if (new_transfer && after_pre_gap)
				transfer_cnt <= 20'd0;   // Slot timing restarts per block
		end
	end

endmodule

`default_nettype wire

// ==== fds_block_tracker.sv ====
// Block type and size tracking to stop the disk position at each block end
`default_nettype none

module fds_block_tracker (
	input  wire                   clk,
	input  wire                   reset,
	input  wire fds_pkg::cpu_bus_t  cpu,
	input  wire [7:0]             disk_data_in,
	input  wire                   disk_write,
	input  wire                   disk_read_strobe,
	input  wire fds_pkg::drive_ctrl_t ctrl,
	input  wire                   new_transfer,
	input  wire                   byte_done,
	output logic                  block_end
);
	import fds_pkg::*;

	logic [15:0] byte_cnt;
	logic [15:0] file_size;
	logic [2:0]  block_type;
	logic        capture;
	logic [7:0]  data;
	logic        last_byte;

	// Disk byte seen on the CPU bus in either direction
	assign capture = cpu.ce && ((disk_read_strobe && ctrl.write_en) || disk_write);
	assign data    = disk_write ? cpu.din : disk_data_in;

	always_comb begin
		case (block_type)
			3'd1:    last_byte = byte_cnt == BLK1_LAST;   // Disk info
			3'd2:    last_byte = byte_cnt == BLK2_LAST;   // File count
			3'd3:    last_byte = byte_cnt == BLK3_LAST;   // File header
			3'd4:    last_byte = byte_cnt == file_size;   // File data
			default: last_byte = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (capture && block_type == 3'd3) begin
			if (byte_cnt == FILE_SIZE_LO_POS)
				file_size[7:0] <= data;
			if (byte_cnt == FILE_SIZE_HI_POS)
				file_size[15:8] <= data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			byte_cnt   <= 16'd0;
			block_type <= 3'd0;
			block_end  <= 1'b0;
		end else begin
			if (capture && byte_cnt == 16'd0)
				block_type <= data[2:0];
			if (byte_done) begin
				byte_cnt <= byte_cnt + 16'd1;
				if (last_byte)
					block_end <= 1'b1;
			end
			if (new_transfer) begin
				byte_cnt   <= 16'd0;
				block_type <= 3'd0;
				block_end  <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== fds_bus_map.sv ====
// PRG and CHR address translation, access allow and status register reads
`default_nettype none

module fds_bus_map (
	input  wire fds_pkg::cpu_bus_t    cpu,
	input  wire [13:0]              chr_addr,
	input  wire fds_pkg::drive_ctrl_t ctrl,
	input  wire [1:0]               side,
	input  wire [15:0]              disk_pos,
	input  wire                     disk_end,
	input  wire                     byte_flag,
	input  wire                     timer_irq,
	input  wire                     disk_write,
	input  wire                     eject_btn,
	output logic [21:0]             prg_aout,
	output logic [7:0]              prg_dout,
	output logic                    prg_allow,
	output logic                    prg_bus_write,
	output logic [21:0]             chr_aout,
	output logic                    vram_a10,
	output logic                    vram_ce
);
	import fds_pkg::*;

	logic        is_ram;
	logic        is_disk;
	logic        disk_ready;
	logic [17:0] side_offset;
	logic [17:0] image_offset;
	logic [21:0] mem_addr;

	assign is_ram  = cpu.addr[15] ^ (&cpu.addr[14:13]);   // $6000-$DFFF
	assign is_disk = cpu.addr == REG_DATA_RD || cpu.addr == REG_DATA_WR;

	// Sides are packed back to back after the file header
	assign side_offset  = SIDE_SIZE * {16'd0, side} + SIDE_HEADER;
	assign image_offset = side_offset + {2'b00, disk_pos};

	assign mem_addr = is_ram ? WRAM_BASE + {7'd0, cpu.addr[14:0]}
		: {9'd0, cpu.addr[12:0]};   // BIOS at the bottom
	assign prg_aout = is_disk ? DISK_BASE + {4'd0, image_offset} : mem_addr;

	assign prg_allow = (cpu.read && (cpu.addr[15] || cpu.addr == REG_DATA_RD))
		|| is_ram || disk_write;

	assign disk_ready = !eject_btn && !ctrl.disk_reset && ctrl.motor_on && !disk_end;

	always_comb begin
		prg_bus_write = 1'b1;
		case (cpu.addr)
			REG_IRQ_STATUS:   prg_dout = {byte_flag, disk_end, 5'd0, timer_irq};
			REG_DRIVE_STATUS: prg_dout = {5'b01000, eject_btn, !disk_ready, eject_btn};
			REG_EXT:          prg_dout = 8'h80;   // Battery good
			default: begin
				prg_dout      = 8'd0;
				prg_bus_write = 1'b0;
			end
		endcase
	end

	// 8 KB CHR RAM, nametables in internal VRAM
	assign chr_aout = CHR_BASE + {9'd0, chr_addr[12:0]};
	assign vram_a10 = ctrl.vertical ? chr_addr[10] : chr_addr[11];
	assign vram_ce  = chr_addr[13];

endmodule

`default_nettype wire

// ==== fds_mapper.sv ====
// FDS RAM adapter mapper top joining drive, block tracker, timer and bus map
`default_nettype none

module fds_mapper (
	input  wire               clk,
	input  wire               reset,
	input  wire fds_pkg::cpu_bus_t cpu,
	input  wire [7:0]         disk_data_in,
	input  wire               eject_btn,
	input  wire [13:0]        chr_addr,
	output logic [21:0]       prg_aout,
	output logic [7:0]        prg_dout,
	output logic              prg_allow,
	output logic              prg_bus_write,
	output logic [21:0]       chr_aout,
	output logic              vram_a10,
	output logic              vram_ce,
	output logic              irq
);
	import fds_pkg::*;

	drive_ctrl_t ctrl;
	logic        io_en;
	logic [1:0]  side;
	logic [15:0] disk_pos;
	logic        byte_flag;
	logic        disk_end;
	logic        disk_write;
	logic        disk_read_strobe;
	logic        new_transfer;
	logic        byte_done;
	logic        status_read_ack;
	logic        block_end;
	logic        timer_irq;

	fds_disk_drive drive_inst (
		.clk(clk), .reset(reset), .cpu(cpu), .eject_btn(eject_btn),
		.block_end(block_end), .ctrl(ctrl), .io_en(io_en), .side(side),
		.disk_pos(disk_pos), .byte_flag(byte_flag), .disk_end(disk_end),
		.disk_write(disk_write), .disk_read_strobe(disk_read_strobe),
		.new_transfer(new_transfer), .byte_done(byte_done),
		.status_read_ack(status_read_ack)
	);

	fds_block_tracker tracker_inst (
		.clk(clk), .reset(reset), .cpu(cpu), .disk_data_in(disk_data_in),
		.disk_write(disk_write), .disk_read_strobe(disk_read_strobe), .ctrl(ctrl),
		.new_transfer(new_transfer), .byte_done(byte_done), .block_end(block_end)
	);

	fds_timer_irq timer_inst (
		.clk(clk), .reset(reset), .cpu(cpu), .io_en(io_en),
		.status_read_ack(status_read_ack), .timer_irq(timer_irq)
	);

	fds_bus_map map_inst (
		.cpu(cpu), .chr_addr(chr_addr), .ctrl(ctrl), .side(side), .disk_pos(disk_pos),
		.disk_end(disk_end), .byte_flag(byte_flag), .timer_irq(timer_irq),
		.disk_write(disk_write), .eject_btn(eject_btn), .prg_aout(prg_aout),
		.prg_dout(prg_dout), .prg_allow(prg_allow), .prg_bus_write(prg_bus_write),
		.chr_aout(chr_aout), .vram_a10(vram_a10), .vram_ce(vram_ce)
	);

	assign irq = timer_irq || (byte_flag && ctrl.disk_irq_en);   // Disk IRQ only when enabled

endmodule

`default_nettype wire

// ==== fds_tb_clock.sv ====
// Free-running testbench clock source with a settable period
`default_nettype none

module fds_tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;   // Half period per phase
	end

endmodule

`default_nettype wire

// ==== fds_mapper_tb.sv ====
// Testbench for the FDS mapper covering timer IRQ, address map, status and disk transfers
`default_nettype none

module fds_mapper_tb;
	import fds_pkg::*;

	localparam int TIMER_N       = 20;
	localparam int SLOT          = int'(BYTE_DELAY) + 1;
	localparam int FIRST_BYTE    = int'(PRE_GAP_DELAY) + 1 + SLOT;   // Motor-on to first slot
	localparam int CONSUME_EDGES = 3;                                 // Read, sample, flag clear
	localparam int TIMEOUT       = int'(PRE_GAP_DELAY) + 40 * SLOT + 2000;

	logic        clk;
	logic        reset;
	cpu_bus_t    cpu;
	logic [7:0]  disk_data_in;
	logic        eject_btn;
	logic [13:0] chr_addr;
	logic [21:0] prg_aout;
	logic [7:0]  prg_dout;
	logic        prg_allow;
	logic        prg_bus_write;
	logic [21:0] chr_aout;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;

	int          cycle = 0;
	int          errors = 0;
	int          checks = 0;
	int          model_pos;   // Expected disk position
	int          blk_cnt;
	int          blk_type;
	logic        blk_end;
	logic [1:0]  side;
	logic [15:0] addr;

	fds_tb_clock #(.PERIOD(8)) clock_inst (.clk(clk));

	fds_mapper fds_mapper_inst (
		.clk(clk), .reset(reset), .cpu(cpu), .disk_data_in(disk_data_in),
		.eject_btn(eject_btn), .chr_addr(chr_addr), .prg_aout(prg_aout),
		.prg_dout(prg_dout), .prg_allow(prg_allow), .prg_bus_write(prg_bus_write),
		.chr_aout(chr_aout), .vram_a10(vram_a10), .vram_ce(vram_ce), .irq(irq)
	);

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT) begin
			$display("TIMEOUT: run did not finish within %0d cycles", TIMEOUT);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic cpu_bus_t make_access(input logic [15:0] a, input logic [7:0] d,
		input logic rd, input logic wr);
		return {a, d, rd, wr, 1'b1};   // ce high every cycle
	endfunction

	// Image address: base, whole sides before this one, file header, position
	function automatic logic [21:0] disk_addr(input logic [1:0] s, input int pos);
		int offset;
		offset = int'(SIDE_SIZE) * s + int'(SIDE_HEADER) + pos;
		return DISK_BASE + offset[21:0];
	endfunction

	function automatic int block_last(input int t);
		case (t)
			1: return int'(BLK1_LAST);
			2: return int'(BLK2_LAST);
			3: return int'(BLK3_LAST);
			default: return -1;   // Type 4 ends at its file size, not fed here
		endcase
	endfunction

	function automatic logic [2:0] drive_status_bits(input logic ej, input logic motor);
		logic ready;
		ready = !ej && motor;
		return {ej, !ready, ej};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic apply_access(input logic [15:0] a, input logic [7:0] d,
		input logic rd, input logic wr);
		@(posedge clk);
		cpu <= make_access(a, d, rd, wr);
		@(negedge clk);   // Combinational outputs settled
	endtask

	task automatic release_bus();
		@(posedge clk);   // Access sampled on this edge
		cpu <= make_access(16'h0000, 8'h00, 1'b0, 1'b0);
	endtask

	task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
		apply_access(a, d, 1'b0, 1'b1);
		release_bus();
	endtask

	task automatic read_check(input logic [15:0] a, input logic [7:0] exp);
		apply_access(a, 8'h00, 1'b1, 1'b0);
		check("prg_dout", prg_dout, exp);
		check("prg_bus_write", prg_bus_write, 1'b1);   // Status byte comes from the mapper
		release_bus();
	endtask

	task automatic check_drive_status(input logic motor);
		apply_access(REG_DRIVE_STATUS, 8'h00, 1'b1, 1'b0);
		check("prg_dout[2:0]", prg_dout[2:0], drive_status_bits(eject_btn, motor));
		release_bus();
	endtask

	task automatic check_irq_next(input logic exp);
		@(posedge clk);
		@(negedge clk);
		check("irq", irq, exp);
	endtask

	// Low after n-1 edges from the reference edge, high after n
	task automatic expect_rise(input int n);
		repeat (n - 1) @(posedge clk);
		@(negedge clk);
		check("irq", irq, 1'b0);
		check_irq_next(1'b1);
	endtask

	task automatic wait_for_irq();
		@(negedge clk);
		while (!irq)
			@(negedge clk);
	endtask

	task automatic check_mirroring(input logic vertical);
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			chr_addr <= 14'($urandom);
			@(negedge clk);
			check("vram_a10", vram_a10, vertical ? chr_addr[10] : chr_addr[11]);
			check("chr_aout", chr_aout, CHR_BASE + {9'd0, chr_addr[12:0]});
			check("vram_ce", vram_ce, chr_addr[13]);   // Nametables from $2000 up
		end
	endtask

	task automatic clear_block_model();
		blk_cnt  = 0;
		blk_type = 0;
		blk_end  = 1'b0;
	endtask

	task automatic start_transfer(input logic [7:0] ctrl_val);
		write_reg(REG_DRIVE_CTRL, ctrl_val & 8'hBF);   // Transfer bit low first
		write_reg(REG_DRIVE_CTRL, ctrl_val);
		clear_block_model();
	endtask

	task automatic consume_byte(input logic [7:0] data);
		@(posedge clk);
		cpu <= make_access(REG_DATA_RD, 8'h00, 1'b1, 1'b0);
		disk_data_in <= data;
		@(negedge clk);
		check("prg_aout", prg_aout, disk_addr(side, model_pos));
		check("prg_allow", prg_allow, 1'b1);
		release_bus();
		check_irq_next(1'b0);   // Byte-ready flag cleared by the read
		if (blk_cnt == 0)
			blk_type = data[2:0];
		if (!blk_end)
			model_pos++;
		if (blk_cnt == block_last(blk_type))
			blk_end = 1'b1;
		blk_cnt++;
	endtask

	initial begin
		void'($urandom(65));
		reset = 1'b1;
		cpu = make_access(16'h0000, 8'h00, 1'b0, 1'b0);
		disk_data_in = 8'h00;
		eject_btn = 1'b0;
		chr_addr = 14'd0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check("irq", irq, 1'b0);
		read_check(REG_IRQ_STATUS, 8'h00);
		read_check(REG_EXT, 8'h80);
		check_drive_status(1'b0);
		@(posedge clk);
		eject_btn <= 1'b1;
		check_drive_status(1'b0);
		@(posedge clk);
		eject_btn <= 1'b0;

		// Timer, one-shot then repeat
		write_reg(REG_IO_EN, 8'h01);
		write_reg(REG_TIMER_LO, 8'(TIMER_N));
		write_reg(REG_TIMER_HI, 8'h00);
		write_reg(REG_TIMER_CTRL, 8'h02);
		expect_rise(TIMER_N + 1);
		read_check(REG_IRQ_STATUS, 8'h01);
		check_irq_next(1'b0);
		repeat (2 * (TIMER_N + 1)) @(posedge clk);
		@(negedge clk);
		check("irq", irq, 1'b0);   // One-shot stays quiet
		write_reg(REG_TIMER_CTRL, 8'h03);
		expect_rise(TIMER_N + 1);
		read_check(REG_IRQ_STATUS, 8'h01);
		check_irq_next(1'b0);
		expect_rise(2 * (TIMER_N + 1) - (TIMER_N + 4));   // N+4 edges already passed
		write_reg(REG_TIMER_CTRL, 8'h00);
		@(negedge clk);
		check("irq", irq, 1'b0);

		// Work RAM and BIOS windows
		for (int i = 0; i < 6; i++) begin
			addr = 16'h6000 + 16'($urandom % 32768);
			apply_access(addr, 8'hA5, !i[0], i[0]);
			check("prg_aout", prg_aout, WRAM_BASE + {7'd0, addr[14:0]});
			check("prg_allow", prg_allow, 1'b1);
			check("prg_bus_write", prg_bus_write, 1'b0);
			release_bus();
		end
		for (int i = 0; i < 3; i++) begin
			addr = (i == 0) ? 16'hE000 : 16'hE000 | 16'($urandom % 8192);
			apply_access(addr, 8'h00, 1'b1, 1'b0);
			check("prg_aout", prg_aout, {9'd0, addr[12:0]});
			check("prg_allow", prg_allow, 1'b1);
			release_bus();
		end
		write_reg(REG_DRIVE_CTRL, 8'h04);   // Bit 3 low selects vertical
		check_mirroring(1'b1);
		write_reg(REG_DRIVE_CTRL, 8'h0C);
		check_mirroring(1'b0);

		// Disk read on a random side
		side = 2'($urandom % 4);
		write_reg(REG_SIDE, {6'd0, side});
		model_pos = 0;
		clear_block_model();
		write_reg(REG_DRIVE_CTRL, 8'hC5);
		expect_rise(FIRST_BYTE);
		for (int i = 0; i < 4; i++) begin
			if (i > 0)
				expect_rise(SLOT - CONSUME_EDGES);
			consume_byte(8'h00);
		end
		check_drive_status(1'b1);

		// Type 2 block stops after two bytes, twice
		for (int pass = 0; pass < 2; pass++) begin
			start_transfer(8'hC5);
			for (int i = 0; i < 4 - pass; i++) begin
				wait_for_irq();
				consume_byte((i == 0) ? 8'h02 : 8'h55);
			end
		end

		// Disk write after the start mark
		start_transfer(8'h41);
		apply_access(REG_DATA_WR, START_MARK, 1'b0, 1'b1);
		check("prg_allow", prg_allow, 1'b0);
		release_bus();
		apply_access(REG_DATA_WR, 8'h3C, 1'b0, 1'b1);
		check("prg_allow", prg_allow, 1'b1);
		check("prg_aout", prg_aout, disk_addr(side, model_pos));
		release_bus();

		repeat (4) @(posedge clk);
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
fds_pkg.sv
fds_timer_irq.sv
fds_disk_drive.sv
fds_block_tracker.sv
fds_bus_map.sv
fds_mapper.sv
fds_tb_clock.sv
fds_mapper_tb.sv
